//--- logic/hazardPkg.sv
`default_nettype none

package hazardPkg;

	localparam int REG_ADDR_W = 5; // MIPS register number
	localparam logic [REG_ADDR_W-1:0] REG_ZERO = '0; // Hardwired zero, never a source

	localparam int FWD_W = 2;
	localparam int CAUSE_W = 3;

	// Bypass mux select
	typedef enum logic [FWD_W-1:0] {
		FWD_NONE = 2'd0, // Register file value
		FWD_EX   = 2'd1,
		FWD_MEM1 = 2'd2,
		FWD_MEM2 = 2'd3
	} fwdSrc_e;

	// Why ID is held this cycle
	typedef enum logic [CAUSE_W-1:0] {
		ST_NONE      = 3'd0,
		ST_RESET     = 3'd1,
		ST_MEM       = 3'd2, // Data cache busy
		ST_LOAD_EX   = 3'd3,
		ST_LOAD_MEM1 = 3'd4,
		ST_BR_EX     = 3'd5, // Branch compares in ID
		ST_BR_MEM2   = 3'd6
	} stallCause_e;

endpackage

`default_nettype wire

//--- logic/stageView.sv
`timescale 1ns/1ns
`default_nettype none

interface stageView;
	import hazardPkg::*;

	// Destination records of the three tracked stages
	logic [REG_ADDR_W-1:0] exRd;
	logic exWr;
	logic exLoad;

	logic [REG_ADDR_W-1:0] mem1Rd;
	logic mem1Wr;
	logic mem1Load;

	logic [REG_ADDR_W-1:0] mem2Rd;
	logic mem2Wr;
	logic mem2Load;

	modport track (
		output exRd, exWr, exLoad,
		output mem1Rd, mem1Wr, mem1Load,
		output mem2Rd, mem2Wr, mem2Load
	);

	modport observe (
		input exRd, exWr, exLoad,
		input mem1Rd, mem1Wr, mem1Load,
		input mem2Rd, mem2Wr, mem2Load
	);

endinterface

`default_nettype wire

//--- logic/stageTracker.sv
`timescale 1ns/1ns
`default_nettype none

module stageTracker (
	input  logic clk,
	input  logic rst_sign,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRd,
	input  logic idRegWrite,
	input  logic idMemRead,
	input  logic issue,
	input  logic hold,
	stageView.track stages
);
	import hazardPkg::*;

	logic advance;
	logic exWrNext;
	logic exLoadNext;

	assign advance = !hold;

	// A bubble enters EX whenever ID does not issue
	assign exWrNext = issue && idRegWrite;
	assign exLoadNext = issue && idMemRead;

	// Control bits of each record
	always_ff @(posedge clk) begin
		if (rst_sign) begin
			stages.exWr <= 1'b0;
			stages.exLoad <= 1'b0;
			stages.mem1Wr <= 1'b0;
			stages.mem1Load <= 1'b0;
			stages.mem2Wr <= 1'b0;
			stages.mem2Load <= 1'b0;
		end else if (advance) begin
			stages.mem2Wr <= stages.mem1Wr;
			stages.mem2Load <= stages.mem1Load;
			stages.mem1Wr <= stages.exWr;
			stages.mem1Load <= stages.exLoad;
			stages.exWr <= exWrNext;
			stages.exLoad <= exLoadNext;
		end
	end

	// Destination numbers
	always_ff @(posedge clk) begin
		if (advance) begin
			stages.mem2Rd <= stages.mem1Rd;
			stages.mem1Rd <= stages.exRd;
			stages.exRd <= issue ? idRd : REG_ZERO;
		end
	end

endmodule

`default_nettype wire

//--- logic/bypassSelect.sv
`timescale 1ns/1ns
`default_nettype none

module bypassSelect (
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRs,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRt,
	stageView.observe stages,
	output hazardPkg::fwdSrc_e fwdRs,
	output hazardPkg::fwdSrc_e fwdRt
);
	import hazardPkg::*;

	// True when a stage will write the wanted register
	function automatic logic stageHit(
		input logic wr,
		input logic [REG_ADDR_W-1:0] rd,
		input logic [REG_ADDR_W-1:0] src
	);
		return wr && (rd != REG_ZERO) && (rd == src);
	endfunction

	// Youngest producer wins
	function automatic fwdSrc_e pickSource(
		input logic [REG_ADDR_W-1:0] src,
		input logic exWr,
		input logic [REG_ADDR_W-1:0] exRd,
		input logic mem1Wr,
		input logic [REG_ADDR_W-1:0] mem1Rd,
		input logic mem2Wr,
		input logic [REG_ADDR_W-1:0] mem2Rd
	);
		fwdSrc_e sel;
		if (stageHit(exWr, exRd, src)) begin
			sel = FWD_EX;
		end else if (stageHit(mem1Wr, mem1Rd, src)) begin
			sel = FWD_MEM1;
		end else if (stageHit(mem2Wr, mem2Rd, src)) begin
			sel = FWD_MEM2;
		end else begin
			sel = FWD_NONE;
		end
		return sel;
	endfunction

	always_comb begin
		fwdRs = pickSource(idRs, stages.exWr, stages.exRd,
			stages.mem1Wr, stages.mem1Rd, stages.mem2Wr, stages.mem2Rd);
	end

	always_comb begin
		fwdRt = pickSource(idRt, stages.exWr, stages.exRd,
			stages.mem1Wr, stages.mem1Rd, stages.mem2Wr, stages.mem2Rd);
	end

endmodule

`default_nettype wire

//--- logic/stallControl.sv
`timescale 1ns/1ns
`default_nettype none

module stallControl (
	input  logic clk,
	input  logic rst_sign,
	input  logic idValid,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRs,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRt,
	input  logic idBranch,
	input  logic memOk,
	stageView.observe stages,
	output logic idReady,
	output logic issue,
	output logic hold
);
	import hazardPkg::*;

	logic rstTail; // Reset stretched by one cycle
	logic inReset;
	logic exLoadUse;
	logic mem1LoadUse;
	logic brExUse;
	logic brMem2Use;
	stallCause_e stallCause;

	// Stage destination is one of the ID sources
	function automatic logic readsDest(
		input logic [REG_ADDR_W-1:0] rd,
		input logic [REG_ADDR_W-1:0] rs,
		input logic [REG_ADDR_W-1:0] rt
	);
		return (rd != REG_ZERO) && ((rd == rs) || (rd == rt));
	endfunction

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			rstTail <= 1'b1;
		end else begin
			rstTail <= 1'b0;
		end
	end

	assign inReset = rst_sign || rstTail;

	// Load data is not ready until MEM2
	assign exLoadUse = stages.exWr && stages.exLoad
		&& readsDest(stages.exRd, idRs, idRt);
	assign mem1LoadUse = stages.mem1Wr && stages.mem1Load
		&& readsDest(stages.mem1Rd, idRs, idRt);

	// Branch compares in ID, so EX results and MEM2 loads arrive too late
	assign brExUse = idBranch && stages.exWr
		&& readsDest(stages.exRd, idRs, idRt);
	assign brMem2Use = idBranch && stages.mem2Wr && stages.mem2Load
		&& readsDest(stages.mem2Rd, idRs, idRt);

	always_comb begin
		if (inReset) begin
			stallCause = ST_RESET;
		end else if (!memOk) begin
			stallCause = ST_MEM;
		end else if (exLoadUse) begin
			stallCause = ST_LOAD_EX;
		end else if (mem1LoadUse) begin
			stallCause = ST_LOAD_MEM1;
		end else if (brExUse) begin
			stallCause = ST_BR_EX;
		end else if (brMem2Use) begin
			stallCause = ST_BR_MEM2;
		end else begin
			stallCause = ST_NONE;
		end
	end

	assign idReady = (stallCause == ST_NONE);
	assign issue = idValid && idReady;
	assign hold = (stallCause == ST_MEM); // Freeze EX, MEM1 and MEM2

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	input  logic clk,
	input  logic rst_sign,
	input  logic idValid,
	output logic idReady,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRs,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRt,
	input  logic [hazardPkg::REG_ADDR_W-1:0] idRd,
	input  logic idRegWrite,
	input  logic idMemRead,
	input  logic idBranch,
	input  logic memOk,
	output hazardPkg::fwdSrc_e fwdRs,
	output hazardPkg::fwdSrc_e fwdRt
);

	logic issue; // ID instruction moves into EX
	logic hold;

	stageView stages ();

	stageTracker uTracker (
		.clk        (clk),
		.rst_sign   (rst_sign),
		.idRd       (idRd),
		.idRegWrite (idRegWrite),
		.idMemRead  (idMemRead),
		.issue      (issue),
		.hold       (hold),
		.stages     (stages.track)
	);

	bypassSelect uBypass (
		.idRs   (idRs),
		.idRt   (idRt),
		.stages (stages.observe),
		.fwdRs  (fwdRs),
		.fwdRt  (fwdRt)
	);

	stallControl uStall (
		.clk      (clk),
		.rst_sign (rst_sign),
		.idValid  (idValid),
		.idRs     (idRs),
		.idRt     (idRt),
		.idBranch (idBranch),
		.memOk    (memOk),
		.stages   (stages.observe),
		.idReady  (idReady),
		.issue    (issue),
		.hold     (hold)
	);

endmodule

`default_nettype wire

//--- bench/hazardUnit_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit_assertions (
	input logic clk,
	input logic rst_sign,
	input logic idValid,
	input logic idReady,
	input logic memOk,
	input logic [hazardPkg::REG_ADDR_W-1:0] idRs,
	input logic [hazardPkg::REG_ADDR_W-1:0] idRt,
	input logic [hazardPkg::REG_ADDR_W-1:0] idRd,
	input logic idRegWrite,
	input logic idMemRead,
	input logic idBranch
);

	int failCount = 0; // Assertion failures so far

	// Data cache busy freezes ID
	memStallNotReady: assert property (@(posedge clk) !memOk |-> !idReady)
		else begin
			failCount++;
			$error("idReady was high while memOk was low");
		end

	// Offered instruction waits unchanged until accepted
	validHeld: assert property (@(posedge clk) disable iff (rst_sign)
		(idValid && !idReady) |=> (idValid && $stable(idRs) && $stable(idRt)
		&& $stable(idRd) && $stable(idRegWrite) && $stable(idMemRead)
		&& $stable(idBranch)))
		else begin
			failCount++;
			$error("ID instruction changed or dropped before acceptance");
		end

	// Reset tail lasts one cycle
	resetTailNotReady: assert property (@(posedge clk) $fell(rst_sign) |-> !idReady)
		else begin
			failCount++;
			$error("idReady was high in the cycle after reset");
		end

endmodule

bind hazardUnit hazardUnit_assertions assertChecks (
	.clk        (clk),
	.rst_sign   (rst_sign),
	.idValid    (idValid),
	.idReady    (idReady),
	.memOk      (memOk),
	.idRs       (idRs),
	.idRt       (idRt),
	.idRd       (idRd),
	.idRegWrite (idRegWrite),
	.idMemRead  (idMemRead),
	.idBranch   (idBranch)
);

`default_nettype wire

//--- bench/hazardTb.sv
`timescale 1ns/1ns
`default_nettype none

module hazardTb;
	import hazardPkg::*;

	localparam int TXN_COUNT = 2000;
	localparam int CYCLE_LIMIT = TXN_COUNT * 4; // Room for stalls and cache waits
	localparam int RESET_CYCLES = 10;

	logic clk = 1'b0;
	logic rst_sign;
	logic idValid;
	logic idReady;
	logic [REG_ADDR_W-1:0] idRs;
	logic [REG_ADDR_W-1:0] idRt;
	logic [REG_ADDR_W-1:0] idRd;
	logic idRegWrite;
	logic idMemRead;
	logic idBranch;
	logic memOk;
	fwdSrc_e fwdRs;
	fwdSrc_e fwdRt;

	logic [31:0] lfsr = 32'hf234;
	logic [31:0] bits;
	int errors = 0;
	int txnCount = 0;
	int cycleCount = 0;
	int edgeCount = 0;
	logic accepted = 1'b0;

	// Model copy of the stage records
	logic [REG_ADDR_W-1:0] mExRd = '0;
	logic mExWr = 1'b0;
	logic mExLoad = 1'b0;
	logic [REG_ADDR_W-1:0] mMem1Rd = '0;
	logic mMem1Wr = 1'b0;
	logic mMem1Load = 1'b0;
	logic [REG_ADDR_W-1:0] mMem2Rd = '0;
	logic mMem2Wr = 1'b0;
	logic mMem2Load = 1'b0;
	logic mTail = 1'b0;
	logic mHold = 1'b0;
	logic mIssue = 1'b0;

	hazardUnit dut0 (
		.clk        (clk),
		.rst_sign   (rst_sign),
		.idValid    (idValid),
		.idReady    (idReady),
		.idRs       (idRs),
		.idRt       (idRt),
		.idRd       (idRd),
		.idRegWrite (idRegWrite),
		.idMemRead  (idMemRead),
		.idBranch   (idBranch),
		.memOk      (memOk),
		.fwdRs      (fwdRs),
		.fwdRt      (fwdRt)
	);

	always #2 clk = ~clk;

	function automatic logic nextBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h80200003; // Taps 32, 22, 2, 1
		end
		return out;
	endfunction

	function automatic logic [31:0] drawBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], nextBit()};
		end
		return v;
	endfunction

	function automatic logic readsReg(input logic [REG_ADDR_W-1:0] rd);
		return (rd != REG_ZERO) && ((rd == idRs) || (rd == idRt));
	endfunction

	// Bypass code of the youngest writer of src
	function automatic logic [31:0] firstMatch(input logic [REG_ADDR_W-1:0] src);
		if (src == REG_ZERO) begin
			return 32'd0;
		end
		if (mExWr && mExRd == src) begin
			return 32'd1;
		end
		if (mMem1Wr && mMem1Rd == src) begin
			return 32'd2;
		end
		if (mMem2Wr && mMem2Rd == src) begin
			return 32'd3;
		end
		return 32'd0;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Fail %s at cycle %0d: expected %0d, actual %0d",
				name, edgeCount, expected, actual);
		end
	endtask

	// Apply the clock edge that just passed
	task automatic advanceModel();
		if (rst_sign) begin
			mExWr = 1'b0;
			mExLoad = 1'b0;
			mMem1Wr = 1'b0;
			mMem1Load = 1'b0;
			mMem2Wr = 1'b0;
			mMem2Load = 1'b0;
		end else if (!mHold) begin
			mMem2Rd = mMem1Rd;
			mMem2Wr = mMem1Wr;
			mMem2Load = mMem1Load;
			mMem1Rd = mExRd;
			mMem1Wr = mExWr;
			mMem1Load = mExLoad;
			mExRd = idRd;
			mExWr = mIssue && idRegWrite; // Bubble when nothing issues
			mExLoad = mIssue && idMemRead;
		end
		mTail = rst_sign;
	endtask

	task automatic driveInputs();
		bits = drawBits(3);
		memOk = (bits != 0); // Low about one cycle in eight
		if (rst_sign) begin
			idValid = 1'b0;
		end else if (!idValid || accepted) begin
			bits = drawBits(3);
			idValid = (bits != 0);
			bits = drawBits(3);
			idRs = REG_ADDR_W'(bits);
			bits = drawBits(3);
			idRt = REG_ADDR_W'(bits);
			bits = drawBits(3);
			idRd = REG_ADDR_W'(bits);
			bits = drawBits(2);
			idRegWrite = (bits != 0);
			bits = drawBits(2);
			idMemRead = (bits == 0);
			bits = drawBits(3);
			idBranch = (bits == 0);
		end
	endtask

	task automatic checkOutputs();
		logic inReset;
		logic stall;
		logic expReady;
		inReset = rst_sign || mTail;
		stall = (mExWr && mExLoad && readsReg(mExRd))
			|| (mMem1Wr && mMem1Load && readsReg(mMem1Rd))
			|| (idBranch && mExWr && readsReg(mExRd))
			|| (idBranch && mMem2Wr && mMem2Load && readsReg(mMem2Rd));
		expReady = !inReset && memOk && !stall;
		mHold = !inReset && !memOk;
		mIssue = idValid && expReady;
		compareValue("idReady", 32'(expReady), 32'(idReady));
		if (idValid) begin
			compareValue("fwdRs", firstMatch(idRs), 32'(fwdRs));
			compareValue("fwdRt", firstMatch(idRt), 32'(fwdRt));
		end
		accepted = idValid && idReady;
		if (accepted) begin
			txnCount++;
		end
	endtask

	initial begin
		rst_sign = 1'b1;
		idValid = 1'b0;
		idRs = '0;
		idRt = '0;
		idRd = '0;
		idRegWrite = 1'b0;
		idMemRead = 1'b0;
		idBranch = 1'b0;
		memOk = 1'b1;
		while (txnCount < TXN_COUNT) begin
			@(posedge clk);
			#1;
			advanceModel();
			edgeCount++;
			rst_sign = (edgeCount < RESET_CYCLES);
			driveInputs();
			#1;
			checkOutputs();
		end
		errors = errors + dut0.assertChecks.failCount;
		$display("Errors: %0d (assertions %0d) in %0d transactions",
			errors, dut0.assertChecks.failCount, txnCount);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles with %0d of %0d transactions done",
			cycleCount, txnCount, TXN_COUNT);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
logic/hazardPkg.sv
logic/stageView.sv
logic/stageTracker.sv
logic/bypassSelect.sv
logic/stallControl.sv
logic/hazardUnit.sv
bench/hazardUnit_assertions.sv
bench/hazardTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = hazardTb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

SOURCES = $(wildcard logic/*.sv bench/*.sv)
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
